// ==== hw/glb_data_pkg.sv ====
/*
 * global buffer data package
 * widths of the host and fabric data paths and the request and
 * response structs that travel on them
 */

`default_nettype none

package glb_data_pkg;

    localparam int BANK_DATA_WIDTH = 64;
    localparam int BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;
    localparam int CGRA_DATA_WIDTH = 16;
    localparam int GLB_ADDR_WIDTH  = 16;

    // fabric lanes per host word, selected by the low lane address bits
    localparam int LANE_SEL_WIDTH = $clog2(BANK_DATA_WIDTH / CGRA_DATA_WIDTH);

    // any nonzero strobe makes it a write
    typedef struct packed {
        logic [BANK_STRB_WIDTH-1:0] wr_strb;
        logic                       rd_en;
        logic [GLB_ADDR_WIDTH-1:0]  addr;
        logic [BANK_DATA_WIDTH-1:0] wr_data;
    } host_req_t;

    typedef struct packed {
        logic [BANK_DATA_WIDTH-1:0] rd_data;
        logic                       rd_valid;
    } host_rsp_t;

    // addr is a lane address within the tile
    typedef struct packed {
        logic                       wr_en;
        logic                       rd_en;
        logic [CGRA_DATA_WIDTH-1:0] addr;
        logic [CGRA_DATA_WIDTH-1:0] wr_data;
    } fabric_req_t;

    typedef struct packed {
        logic [CGRA_DATA_WIDTH-1:0] rd_data;
        logic                       rd_valid;
    } fabric_rsp_t;

endpackage

`default_nettype wire

// ==== hw/glb_cfg_pkg.sv ====
/*
 * global buffer config package
 * config bus layout, register indices and the per-tile
 * configuration struct
 */

`default_nettype none

package glb_cfg_pkg;

    localparam int CFG_ADDR_WIDTH    = 8;
    localparam int CFG_DATA_WIDTH    = 32;
    localparam int CFG_REG_IDX_WIDTH = 4;
    localparam int CFG_TILE_ID_WIDTH = CFG_ADDR_WIDTH - CFG_REG_IDX_WIDTH;
    localparam int BASE_WIDTH        = 16;

    typedef logic [CFG_TILE_ID_WIDTH-1:0] cfg_tile_id_t;
    typedef logic [CFG_REG_IDX_WIDTH-1:0] cfg_reg_idx_t;

    // register map, bit 0 of ctrl is the fabric enable
    localparam cfg_reg_idx_t REG_CTRL = 4'd0;
    localparam cfg_reg_idx_t REG_BASE = 4'd1;

    // addr is {tile id, register index}
    typedef struct packed {
        logic                      wr;
        logic                      rd;
        logic [CFG_ADDR_WIDTH-1:0] addr;
        logic [CFG_DATA_WIDTH-1:0] wr_data;
    } cfg_req_t;

    typedef struct packed {
        logic                  fabric_en;
        logic [BASE_WIDTH-1:0] base;
    } tile_cfg_t;

endpackage

`default_nettype wire

// ==== hw/glb_bank.sv ====
/*
 * glb bank
 * word memory of one tile with two ports: host port writes under
 * byte strobes, fabric port accesses one 16-bit lane per cycle
 * both read ports are registered
 */

`timescale 1ns/100ps
`default_nettype none

module glb_bank #(
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                                     clk,
    input  logic                                     host_en,
    input  logic [glb_data_pkg::BANK_STRB_WIDTH-1:0] host_wr_strb,
    input  logic [BANK_ADDR_WIDTH-1:0]               host_addr,
    input  logic [glb_data_pkg::BANK_DATA_WIDTH-1:0] host_wr_data,
    output logic [glb_data_pkg::BANK_DATA_WIDTH-1:0] host_rd_data,
    input  logic                                     fab_en,
    input  logic                                     fab_wr,
    input  logic [glb_data_pkg::LANE_SEL_WIDTH-1:0]  fab_lane,
    input  logic [BANK_ADDR_WIDTH-1:0]               fab_addr,
    input  logic [glb_data_pkg::CGRA_DATA_WIDTH-1:0] fab_wr_data,
    output logic [glb_data_pkg::CGRA_DATA_WIDTH-1:0] fab_rd_data
);

    localparam int DEPTH  = 2 ** BANK_ADDR_WIDTH;
    localparam int DW     = glb_data_pkg::BANK_DATA_WIDTH;
    localparam int CW     = glb_data_pkg::CGRA_DATA_WIDTH;
    localparam int NSTRB  = glb_data_pkg::BANK_STRB_WIDTH;
    localparam int BYTE_W = DW / NSTRB;

    logic [DW-1:0] mem [DEPTH];

    // host bytes come last so they win a same-word conflict
    always_ff @(posedge clk) begin
        if (fab_en && fab_wr) begin
            mem[fab_addr][fab_lane*CW +: CW] <= fab_wr_data;
        end
        if (host_en) begin
            for (int b = 0; b < NSTRB; b++) begin
                if (host_wr_strb[b]) begin
                    mem[host_addr][b*BYTE_W +: BYTE_W] <= host_wr_data[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // read before write on both ports
    always_ff @(posedge clk) begin
        if (host_en) begin
            host_rd_data <= mem[host_addr];
        end
        if (fab_en) begin
            fab_rd_data <= mem[fab_addr][fab_lane*CW +: CW];
        end
    end

endmodule

`default_nettype wire

// ==== hw/glb_cfg_regs.sv ====
/*
 * glb config registers
 * fabric enable and base word offset of one tile, written and
 * read back over the shared config bus
 */

`timescale 1ns/100ps
`default_nettype none

module glb_cfg_regs #(
    parameter int TILE_ID         = 0,
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  glb_cfg_pkg::cfg_req_t                   cfg_req,
    output logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0]  cfg_rd_data,
    output glb_cfg_pkg::tile_cfg_t                  tile_cfg
);

    localparam int RIW = glb_cfg_pkg::CFG_REG_IDX_WIDTH;

    logic                                   tile_hit;
    glb_cfg_pkg::cfg_reg_idx_t              reg_idx;
    logic [glb_cfg_pkg::BASE_WIDTH-1:0]     base_wr;
    logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0] rd_val;

    assign tile_hit = cfg_req.addr[glb_cfg_pkg::CFG_ADDR_WIDTH-1:RIW]
                      == glb_cfg_pkg::cfg_tile_id_t'(TILE_ID);
    assign reg_idx  = cfg_req.addr[RIW-1:0];

    // base only keeps the bits that address a word in the bank
    always_comb begin
        base_wr = '0;
        base_wr[BANK_ADDR_WIDTH-1:0] = cfg_req.wr_data[BANK_ADDR_WIDTH-1:0];
    end

    always_comb begin
        rd_val = '0;
        if (tile_hit) begin
            case (reg_idx)
                glb_cfg_pkg::REG_CTRL: rd_val[0] = tile_cfg.fabric_en;
                glb_cfg_pkg::REG_BASE: rd_val[glb_cfg_pkg::BASE_WIDTH-1:0] = tile_cfg.base;
                default:               rd_val = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tile_cfg <= '0;
        end else if (cfg_req.wr && tile_hit) begin
            if (reg_idx == glb_cfg_pkg::REG_CTRL) begin
                tile_cfg.fabric_en <= cfg_req.wr_data[0];
            end
            if (reg_idx == glb_cfg_pkg::REG_BASE) begin
                tile_cfg.base <= base_wr;
            end
        end
    end

    // read data lives for one cycle, zero otherwise
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_rd_data <= '0;
        end else begin
            cfg_rd_data <= cfg_req.rd ? rd_val : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/glb_tile.sv ====
/*
 * glb tile
 * one slice of the global buffer: forwards host requests west,
 * serves the ones addressed to its bank, merges its read data onto
 * the eastbound return path and translates fabric lane addresses
 */

`timescale 1ns/100ps
`default_nettype none

module glb_tile #(
    parameter int TILE_ID         = 0,
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  glb_data_pkg::host_req_t                host_req_east,
    output glb_data_pkg::host_req_t                host_req_west,
    input  glb_data_pkg::host_rsp_t                host_rsp_west,
    output glb_data_pkg::host_rsp_t                host_rsp_east,
    input  glb_data_pkg::fabric_req_t              fabric_req,
    output glb_data_pkg::fabric_rsp_t              fabric_rsp,
    input  glb_cfg_pkg::cfg_req_t                  cfg_req,
    output logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0] cfg_rd_data
);

    localparam int AW        = glb_data_pkg::GLB_ADDR_WIDTH;
    localparam int TILE_SEL_W = AW - BANK_ADDR_WIDTH;

    glb_cfg_pkg::tile_cfg_t                   tile_cfg;
    logic                                     host_hit;
    logic                                     host_en;
    logic [glb_data_pkg::BANK_STRB_WIDTH-1:0] host_wr_strb;
    logic [glb_data_pkg::BANK_DATA_WIDTH-1:0] host_rd_data;
    logic [glb_data_pkg::BANK_DATA_WIDTH-1:0] own_rd_data;
    logic                                     host_rd_q;
    logic                                     fab_en;
    logic [glb_data_pkg::LANE_SEL_WIDTH-1:0]  fab_lane;
    logic [glb_cfg_pkg::BASE_WIDTH-1:0]       fab_word;
    logic [glb_data_pkg::CGRA_DATA_WIDTH-1:0] fab_rd_data;
    logic                                     fab_rd_q;

    // upper address bits pick the tile
    assign host_hit     = host_req_east.addr[AW-1:BANK_ADDR_WIDTH] == TILE_SEL_W'(TILE_ID);
    assign host_en      = host_hit && (host_req_east.rd_en || (|host_req_east.wr_strb));
    assign host_wr_strb = host_hit ? host_req_east.wr_strb : '0;

    // one stage per tile toward the west
    always_ff @(posedge clk) begin
        if (rst) begin
            host_req_west <= '0;
        end else begin
            host_req_west <= host_req_east;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            host_rd_q <= 1'b0;
        end else begin
            host_rd_q <= host_hit && host_req_east.rd_en;
        end
    end

    // only the tile that served the read puts data on the return path
    assign own_rd_data = host_rd_q ? host_rd_data : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            host_rsp_east.rd_valid <= 1'b0;
        end else begin
            host_rsp_east.rd_valid <= host_rsp_west.rd_valid | host_rd_q;
        end
        host_rsp_east.rd_data <= host_rsp_west.rd_data | own_rd_data;
    end

    // fabric word = lane address / 4 + base, wraps at the bank size
    assign fab_lane = fabric_req.addr[glb_data_pkg::LANE_SEL_WIDTH-1:0];
    assign fab_word = (fabric_req.addr >> glb_data_pkg::LANE_SEL_WIDTH) + tile_cfg.base;
    assign fab_en   = tile_cfg.fabric_en && (fabric_req.rd_en || fabric_req.wr_en);

    always_ff @(posedge clk) begin
        if (rst) begin
            fab_rd_q <= 1'b0;
        end else begin
            fab_rd_q <= tile_cfg.fabric_en && fabric_req.rd_en;
        end
    end

    always_comb begin
        fabric_rsp.rd_data  = fab_rd_data;
        fabric_rsp.rd_valid = fab_rd_q;
    end

    glb_bank #(
        .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
    ) i_glb_bank (
        .clk          (clk),
        .host_en      (host_en),
        .host_wr_strb (host_wr_strb),
        .host_addr    (host_req_east.addr[BANK_ADDR_WIDTH-1:0]),
        .host_wr_data (host_req_east.wr_data),
        .host_rd_data (host_rd_data),
        .fab_en       (fab_en),
        .fab_wr       (fabric_req.wr_en),
        .fab_lane     (fab_lane),
        .fab_addr     (fab_word[BANK_ADDR_WIDTH-1:0]),
        .fab_wr_data  (fabric_req.wr_data),
        .fab_rd_data  (fab_rd_data)
    );

    glb_cfg_regs #(
        .TILE_ID         (TILE_ID),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) i_glb_cfg_regs (
        .clk         (clk),
        .rst         (rst),
        .cfg_req     (cfg_req),
        .cfg_rd_data (cfg_rd_data),
        .tile_cfg    (tile_cfg)
    );

endmodule

`default_nettype wire

// ==== hw/global_buffer.sv ====
/*
 * global buffer
 * row of NUM_TILES tiles; host requests enter at the east end and
 * travel west, read data returns east, each tile has its own fabric
 * port and the config read-back is ORed over all tiles
 */

`timescale 1ns/100ps
`default_nettype none

module global_buffer #(
    parameter int NUM_TILES       = 4,
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  glb_data_pkg::host_req_t                host_req,
    output glb_data_pkg::host_rsp_t                host_rsp,
    input  glb_data_pkg::fabric_req_t              fabric_req [0:NUM_TILES-1],
    output glb_data_pkg::fabric_rsp_t              fabric_rsp [0:NUM_TILES-1],
    input  glb_cfg_pkg::cfg_req_t                  cfg_req,
    output logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0] cfg_rd_data
);

    glb_data_pkg::host_req_t                req_esti [0:NUM_TILES-1];
    glb_data_pkg::host_req_t                req_wsto [0:NUM_TILES-1];
    glb_data_pkg::host_rsp_t                rsp_wsti [0:NUM_TILES-1];
    glb_data_pkg::host_rsp_t                rsp_esto [0:NUM_TILES-1];
    logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0] tile_cfg_rd_data [0:NUM_TILES-1];

    for (genvar i = 0; i < NUM_TILES; i++) begin : gen_tile
        // requests from the host or from the eastern neighbour
        if (i == NUM_TILES-1) begin : gen_east_end
            assign req_esti[i] = host_req;
        end else begin : gen_east_link
            assign req_esti[i] = req_wsto[i+1];
        end

        // west end of the return chain starts empty
        if (i == 0) begin : gen_west_end
            assign rsp_wsti[i] = '0;
        end else begin : gen_west_link
            assign rsp_wsti[i] = rsp_esto[i-1];
        end

        glb_tile #(
            .TILE_ID         (i),
            .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
        ) i_glb_tile (
            .clk           (clk),
            .rst           (rst),
            .host_req_east (req_esti[i]),
            .host_req_west (req_wsto[i]),
            .host_rsp_west (rsp_wsti[i]),
            .host_rsp_east (rsp_esto[i]),
            .fabric_req    (fabric_req[i]),
            .fabric_rsp    (fabric_rsp[i]),
            .cfg_req       (cfg_req),
            .cfg_rd_data   (tile_cfg_rd_data[i])
        );
    end

    assign host_rsp = rsp_esto[NUM_TILES-1];

    // at most one tile answers a config read
    always_comb begin
        cfg_rd_data = '0;
        for (int i = 0; i < NUM_TILES; i++) begin
            cfg_rd_data = cfg_rd_data | tile_cfg_rd_data[i];
        end
    end

endmodule

`default_nettype wire

// ==== sim/glb_checker.sv ====
/*
 * global buffer checker
 * reference model of the banks and config registers, updated from
 * the observed requests; compares every DUT response
 */

`timescale 1ns/100ps
`default_nettype none

module glb_checker #(
    parameter int NUM_TILES       = 4,
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  int                                     phase,
    input  glb_data_pkg::host_req_t                host_req,
    input  glb_data_pkg::host_rsp_t                host_rsp,
    input  glb_data_pkg::fabric_req_t              fabric_req [0:NUM_TILES-1],
    input  glb_data_pkg::fabric_rsp_t              fabric_rsp [0:NUM_TILES-1],
    input  glb_cfg_pkg::cfg_req_t                  cfg_req,
    input  logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0] cfg_rd_data,
    output int                                     check_count,
    output int                                     error_count,
    output int                                     reads_pending
);

    localparam int DEPTH = 2 ** BANK_ADDR_WIDTH;
    localparam int CW    = glb_data_pkg::CGRA_DATA_WIDTH;
    localparam int LANES = glb_data_pkg::BANK_DATA_WIDTH / CW;

    logic [glb_data_pkg::BANK_DATA_WIDTH-1:0] mem [NUM_TILES][DEPTH];
    logic                                     ctrl_reg [NUM_TILES];
    int                                       base_reg [NUM_TILES];
    // host requests seen at the top, index = edges ago
    glb_data_pkg::host_req_t                  hist [NUM_TILES];
    logic [glb_data_pkg::BANK_DATA_WIDTH-1:0] host_exp [$];
    logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0]   cfg_exp;
    logic                                     fab_exp_valid [NUM_TILES];
    logic [CW-1:0]                            fab_exp_data [NUM_TILES];

    function automatic string phase_name(int p);
        case (p)
            1:       return "config";
            2:       return "host_write";
            3:       return "host_read";
            4:       return "fabric";
            5:       return "mixed";
            default: return "reset";
        endcase
    endfunction

    task automatic compare(string what, logic [63:0] exp, logic [63:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error [%s] %s: expected %0h, actual %0h",
                     phase_name(phase), what, exp, act);
        end
    endtask

    // zero for an unknown tile or register
    function automatic logic [31:0] cfg_value(logic [7:0] addr);
        int tile;
        tile = addr[7:4];
        if (tile >= NUM_TILES) return '0;
        if (addr[3:0] == glb_cfg_pkg::REG_CTRL) return 32'(ctrl_reg[tile]);
        if (addr[3:0] == glb_cfg_pkg::REG_BASE) return 32'(base_reg[tile]);
        return '0;
    endfunction

    always @(posedge clk) begin : model_step
        int word;
        int lane;
        int tile;
        glb_data_pkg::host_req_t r;
        if (rst) begin
            for (int k = 0; k < NUM_TILES; k++) begin
                hist[k]          = '0;
                ctrl_reg[k]      = 1'b0;
                base_reg[k]      = 0;
                fab_exp_valid[k] = 1'b0;
            end
            cfg_exp = '0;
            host_exp.delete();
            check_count   = 0;
            error_count   = 0;
            reads_pending = 0;
        end else begin
            // responses to the previous edge
            compare("cfg_rd_data", cfg_exp, cfg_rd_data);
            for (int k = 0; k < NUM_TILES; k++) begin
                compare($sformatf("fabric %0d rd_valid", k),
                        fab_exp_valid[k], fabric_rsp[k].rd_valid);
                if (fab_exp_valid[k]) begin
                    compare($sformatf("fabric %0d rd_data", k),
                            fab_exp_data[k], fabric_rsp[k].rd_data);
                end
            end
            if (host_rsp.rd_valid !== 1'b0) begin
                if (host_exp.size() == 0) begin
                    error_count++;
                    $display("host rd_valid arrived with no read outstanding in test %s",
                             phase_name(phase));
                end else begin
                    compare("host rd_data", host_exp.pop_front(), host_rsp.rd_data);
                end
            end

            cfg_exp = cfg_req.rd ? cfg_value(cfg_req.addr) : '0;
            for (int d = NUM_TILES - 1; d > 0; d--) begin
                hist[d] = hist[d-1];
            end
            hist[0] = host_req;

            // per tile: reads see old data, then fabric writes, host bytes last
            for (int k = 0; k < NUM_TILES; k++) begin
                word = ((fabric_req[k].addr / LANES) + base_reg[k]) % DEPTH;
                lane = fabric_req[k].addr % LANES;
                fab_exp_valid[k] = ctrl_reg[k] && fabric_req[k].rd_en;
                fab_exp_data[k]  = mem[k][word][lane*CW +: CW];
                r = hist[NUM_TILES-1-k];
                if (int'(r.addr >> BANK_ADDR_WIDTH) == k && r.rd_en) begin
                    host_exp.push_back(mem[k][r.addr % DEPTH]);
                end
                if (ctrl_reg[k] && fabric_req[k].wr_en) begin
                    mem[k][word][lane*CW +: CW] = fabric_req[k].wr_data;
                end
                if (int'(r.addr >> BANK_ADDR_WIDTH) == k) begin
                    for (int b = 0; b < glb_data_pkg::BANK_STRB_WIDTH; b++) begin
                        if (r.wr_strb[b]) begin
                            mem[k][r.addr % DEPTH][b*8 +: 8] = r.wr_data[b*8 +: 8];
                        end
                    end
                end
            end

            tile = cfg_req.addr[7:4];
            if (cfg_req.wr && tile < NUM_TILES) begin
                if (cfg_req.addr[3:0] == glb_cfg_pkg::REG_CTRL) begin
                    ctrl_reg[tile] = cfg_req.wr_data[0];
                end
                if (cfg_req.addr[3:0] == glb_cfg_pkg::REG_BASE) begin
                    base_reg[tile] = cfg_req.wr_data % DEPTH;
                end
            end
            reads_pending = host_exp.size();
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_global_buffer.sv ====
/*
 * global buffer testbench
 * drives config, host and fabric traffic from a seeded random
 * source in five phases; glb_checker compares every response
 */

`timescale 1ns/100ps
`default_nettype none

module tb_global_buffer;

    localparam int NUM_TILES       = 4;
    localparam int BANK_ADDR_WIDTH = 6;
    localparam int DEPTH           = 2 ** BANK_ADDR_WIDTH;
    localparam int CLK_PERIOD      = 100;
    localparam int CFG_WRITES      = 16;
    localparam int CFG_UNKNOWN     = 8;
    localparam int HOST_WRITES     = 64;
    localparam int HOST_READS      = 32;
    localparam int FABRIC_CYCLES   = 64;
    localparam int MIX_CYCLES      = 128;
    // requests over all phases
    localparam int TOTAL_REQS = 2 * NUM_TILES + 2 * CFG_WRITES + CFG_UNKNOWN
                                + NUM_TILES * DEPTH + HOST_WRITES + HOST_READS
                                + 2 * NUM_TILES + FABRIC_CYCLES
                                + NUM_TILES * DEPTH + MIX_CYCLES;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 4 * NUM_TILES + 100;

    logic                                   clk;
    logic                                   rst;
    int                                     phase;
    integer                                 seed;
    glb_data_pkg::host_req_t                host_req;
    glb_data_pkg::host_rsp_t                host_rsp;
    glb_data_pkg::fabric_req_t              fabric_req [0:NUM_TILES-1];
    glb_data_pkg::fabric_rsp_t              fabric_rsp [0:NUM_TILES-1];
    glb_cfg_pkg::cfg_req_t                  cfg_req;
    logic [glb_cfg_pkg::CFG_DATA_WIDTH-1:0] cfg_rd_data;
    int                                     check_count;
    int                                     error_count;
    int                                     reads_pending;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // inputs change 1 ns after the rising edge
    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    task automatic cfg_write(int tile, int idx, logic [31:0] data);
        cfg_req.wr      = 1'b1;
        cfg_req.addr    = {4'(tile), 4'(idx)};
        cfg_req.wr_data = data;
        step_clock();
        cfg_req = '0;
    endtask

    task automatic cfg_read(int tile, int idx);
        cfg_req.rd   = 1'b1;
        cfg_req.addr = {4'(tile), 4'(idx)};
        step_clock();
        cfg_req = '0;
    endtask

    task automatic host_write(int addr, logic [63:0] data, logic [7:0] strb);
        host_req         = '0;
        host_req.addr    = 16'(addr);
        host_req.wr_strb = strb;
        host_req.wr_data = data;
        step_clock();
        host_req = '0;
    endtask

    // one read in flight, wait for its rd_valid
    task automatic host_read(int addr);
        host_req       = '0;
        host_req.rd_en = 1'b1;
        host_req.addr  = 16'(addr);
        step_clock();
        host_req = '0;
        do @(posedge clk); while (host_rsp.rd_valid !== 1'b1);
        #1;
    endtask

    // one cycle of random traffic on every fabric port
    task automatic drive_fabric();
        int op;
        for (int k = 0; k < NUM_TILES; k++) begin
            op = {$random(seed)} % 4;
            fabric_req[k].rd_en   = (op == 1) || (op == 3);
            fabric_req[k].wr_en   = (op == 2);
            fabric_req[k].addr    = 16'($random(seed));
            fabric_req[k].wr_data = 16'($random(seed));
        end
        step_clock();
        for (int k = 0; k < NUM_TILES; k++) begin
            fabric_req[k] = '0;
        end
    endtask

    function automatic logic [63:0] fill_word(int addr);
        return {4{16'(addr)}} ^ 64'h5a3c_96e1_0f87_d24b;
    endfunction

    initial begin : stimulus
        int tile;
        int idx;
        int fails;
        seed     = 77;
        phase    = 0;
        rst      = 1'b1;
        host_req = '0;
        cfg_req  = '0;
        for (int k = 0; k < NUM_TILES; k++) begin
            fabric_req[k] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset values, then random register writes with read-back
        phase = 1;
        repeat (4) step_clock();
        for (int k = 0; k < NUM_TILES; k++) begin
            cfg_read(k, glb_cfg_pkg::REG_CTRL);
            cfg_read(k, glb_cfg_pkg::REG_BASE);
        end
        for (int i = 0; i < CFG_WRITES; i++) begin
            tile = {$random(seed)} % NUM_TILES;
            idx  = {$random(seed)} % 2;
            cfg_write(tile, idx, $random(seed));
            cfg_read(tile, idx);
        end
        for (int i = 0; i < CFG_UNKNOWN; i++) begin
            if (i % 2 == 0 || NUM_TILES == 16) begin
                cfg_read({$random(seed)} % NUM_TILES, 2 + {$random(seed)} % 14);
            end else begin
                cfg_read(NUM_TILES + {$random(seed)} % (16 - NUM_TILES), {$random(seed)} % 2);
            end
        end

        // full fill first so no byte stays unknown
        phase = 2;
        for (int a = 0; a < NUM_TILES * DEPTH; a++) begin
            host_write(a, fill_word(a), '1);
        end
        for (int i = 0; i < HOST_WRITES; i++) begin
            host_write({$random(seed)} % (NUM_TILES * DEPTH),
                       {$random(seed), $random(seed)}, 8'($random(seed)));
        end

        phase = 3;
        for (int i = 0; i < HOST_READS; i++) begin
            host_read((i % NUM_TILES) * DEPTH + {$random(seed)} % DEPTH);
        end

        // tile 1 keeps its fabric port off
        phase = 4;
        for (int k = 0; k < NUM_TILES; k++) begin
            cfg_write(k, glb_cfg_pkg::REG_BASE, $random(seed));
            cfg_write(k, glb_cfg_pkg::REG_CTRL, 32'(k != 1));
        end
        repeat (FABRIC_CYCLES) drive_fabric();

        phase = 5;
        fork
            for (int a = 0; a < NUM_TILES * DEPTH; a++) begin
                host_read(a);
            end
            repeat (MIX_CYCLES) drive_fabric();
        join
        repeat (5) step_clock();

        fails = error_count;
        if (reads_pending != 0) begin
            $display("%0d host reads never returned rd_valid", reads_pending);
            fails++;
        end
        $display("checks: %0d, errors: %0d", check_count, fails);
        if (fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("timeout: run stopped after %0d clock periods", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    global_buffer #(
        .NUM_TILES       (NUM_TILES),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) i_global_buffer (
        .clk         (clk),
        .rst         (rst),
        .host_req    (host_req),
        .host_rsp    (host_rsp),
        .fabric_req  (fabric_req),
        .fabric_rsp  (fabric_rsp),
        .cfg_req     (cfg_req),
        .cfg_rd_data (cfg_rd_data)
    );

    glb_checker #(
        .NUM_TILES       (NUM_TILES),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) i_glb_checker (
        .clk           (clk),
        .rst           (rst),
        .phase         (phase),
        .host_req      (host_req),
        .host_rsp      (host_rsp),
        .fabric_req    (fabric_req),
        .fabric_rsp    (fabric_rsp),
        .cfg_req       (cfg_req),
        .cfg_rd_data   (cfg_rd_data),
        .check_count   (check_count),
        .error_count   (error_count),
        .reads_pending (reads_pending)
    );

endmodule

`default_nettype wire

// ==== project.f ====
hw/glb_data_pkg.sv
hw/glb_cfg_pkg.sv
hw/glb_bank.sv
hw/glb_cfg_regs.sv
hw/glb_tile.sv
hw/global_buffer.sv
sim/glb_checker.sv
sim/tb_global_buffer.sv

// ==== Bender.yml ====
package:
  name: global_buffer

sources:
  - files:
      - hw/glb_data_pkg.sv
      - hw/glb_cfg_pkg.sv
      - hw/glb_bank.sv
      - hw/glb_cfg_regs.sv
      - hw/glb_tile.sv
      - hw/global_buffer.sv
  - target: simulation
    files:
      - sim/glb_checker.sv
      - sim/tb_global_buffer.sv

# testbench top: tb_global_buffer
# design top: global_buffer
